//--- hdl/alpha_pkg.sv
// Signed Q1.15 operands; accumulator width covers at most 255 terms of two full-scale products
package alpha_pkg;

    // Operand format
    parameter int COEF_WIDTH = 16;   // Signed Q1.15

    // Full-width product of two operands
    parameter int PROD_WIDTH = 2 * COEF_WIDTH;

    // 255 terms of two products each need 9 guard bits
    parameter int ACC_WIDTH = 41;

    parameter int TERM_COUNT_WIDTH = 8;

    // Pipeline depth of a product lane unless the top level overrides it
    parameter int DEFAULT_MULT_STAGES = 3;

    typedef logic signed [COEF_WIDTH-1:0] coef_t;

    typedef logic signed [PROD_WIDTH-1:0] prod_t;   // Q2.30

    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    typedef logic [TERM_COUNT_WIDTH-1:0] term_count_t;   // Terms in one frame

endpackage

//--- hdl/product_if.sv
// Valid/ready stream of one lane; the source holds product and last while valid waits on ready
`timescale 1ns/1ns

interface product_if;

    import alpha_pkg::*;

    logic  valid;
    logic  ready;
    prod_t product;
    logic  last;      // Final term of the frame

    modport source (
        output valid,
        output product,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  product,
        input  last,
        output ready
    );

endinterface

//--- hdl/product_lane.sv
// Latency is MULT_STAGES cycles without stalls; MULT_STAGES must be 1 or more
`timescale 1ns/1ns

module product_lane #(
    parameter int MULT_STAGES = alpha_pkg::DEFAULT_MULT_STAGES
) (
    input  logic             iClock,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  alpha_pkg::coef_t in_a,
    input  alpha_pkg::coef_t in_b,
    input  logic             in_last,
    product_if.source        out
);

    import alpha_pkg::*;

    logic [MULT_STAGES-1:0] valid_q;   // One bit per stage
    logic [MULT_STAGES-1:0] last_q;
    logic [MULT_STAGES-1:0] advance;   // Stage loads this cycle
    coef_t                  op_a;
    coef_t                  op_b;
    prod_t                  mult_result;

    assign mult_result = op_a * op_b;   // Signed, full width

    // A stage is blocked only if it and every stage after it are full and out stalls
    always_comb begin
        logic blocked;
        blocked = !out.ready;
        for (int k = MULT_STAGES - 1; k >= 0; k--) begin
            blocked = blocked && valid_q[k];
            advance[k] = !blocked;
        end
    end

    assign in_ready  = advance[0];
    assign out.valid = valid_q[MULT_STAGES-1];
    assign out.last  = last_q[MULT_STAGES-1];

    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            valid_q <= '0;
            last_q  <= '0;
            op_a    <= '0;
            op_b    <= '0;
        end else begin
            if (advance[0]) begin
                valid_q[0] <= in_valid;
                if (in_valid) begin
                    op_a      <= in_a;   // Operand register is stage 0
                    op_b      <= in_b;
                    last_q[0] <= in_last;
                end
            end
            for (int k = 1; k < MULT_STAGES; k++) begin
                if (advance[k]) begin
                    valid_q[k] <= valid_q[k-1];
                    if (valid_q[k-1]) begin
                        last_q[k] <= last_q[k-1];
                    end
                end
            end
        end
    end

    generate
        if (MULT_STAGES == 1) begin : g_single
            assign out.product = mult_result;   // Straight from the operand register
        end else begin : g_pipe
            prod_t prod_q [1:MULT_STAGES-1];

            always_ff @(posedge iClock) begin
                if (!rst_n) begin
                    for (int k = 1; k < MULT_STAGES; k++) begin
                        prod_q[k] <= '0;
                    end
                end else begin
                    if (advance[1] && valid_q[0]) begin
                        prod_q[1] <= mult_result;
                    end
                    for (int k = 2; k < MULT_STAGES; k++) begin
                        if (advance[k] && valid_q[k-1]) begin
                            prod_q[k] <= prod_q[k-1];
                        end
                    end
                end
            end

            assign out.product = prod_q[MULT_STAGES-1];
        end
    endgenerate

endmodule

//--- hdl/alpha_accumulator.sv
// Both lanes must run in lock step; a frame ends on the last flag and holds at most 255 terms
`timescale 1ns/1ns

module alpha_accumulator (
    input  logic                   iClock,
    input  logic                   rst_n,
    product_if.sink                lane_a,
    product_if.sink                lane_b,
    output logic                   alpha_valid,
    input  logic                   alpha_ready,
    output alpha_pkg::acc_t        alpha,
    output alpha_pkg::term_count_t alpha_terms
);

    import alpha_pkg::*;

    localparam int EXT_WIDTH = ACC_WIDTH - PROD_WIDTH;

    acc_t        ext_a;       // Sign-extended lane products
    acc_t        ext_b;
    acc_t        pair_sum;
    acc_t        frame_sum;   // Sum including the current term
    acc_t        acc_sum;
    term_count_t term_count;
    term_count_t frame_terms;
    logic        take;
    logic        frame_end;

    // Join of the two streams, closed while a result waits
    assign take = lane_a.valid && lane_b.valid && !alpha_valid;

    assign lane_a.ready = take;
    assign lane_b.ready = take;

    assign frame_end = lane_a.last && lane_b.last;

    assign ext_a = {{EXT_WIDTH{lane_a.product[PROD_WIDTH-1]}}, lane_a.product};
    assign ext_b = {{EXT_WIDTH{lane_b.product[PROD_WIDTH-1]}}, lane_b.product};

    assign pair_sum    = ext_a + ext_b;
    assign frame_sum   = acc_sum + pair_sum;
    assign frame_terms = term_count + 1'b1;

    // Running sum over the frame
    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            acc_sum    <= '0;
            term_count <= '0;
        end else if (take) begin
            if (frame_end) begin
                acc_sum    <= '0;   // Next frame starts clean
                term_count <= '0;
            end else begin
                acc_sum    <= frame_sum;
                term_count <= frame_terms;
            end
        end
    end

    // Held result, released by alpha_ready
    always_ff @(posedge iClock) begin
        if (!rst_n) begin
            alpha_valid <= 1'b0;
            alpha       <= '0;
            alpha_terms <= '0;
        end else begin
            if (take && frame_end) begin
                alpha_valid <= 1'b1;
                alpha       <= frame_sum;
                alpha_terms <= frame_terms;
            end else if (alpha_valid && alpha_ready) begin
                alpha_valid <= 1'b0;   // Data kept until overwritten
            end
        end
    end

endmodule

//--- hdl/alpha_calculator.sv
// Alpha is exact in fixed point; frames end on in_last and must not exceed 255 terms
`timescale 1ns/1ns

module alpha_calculator #(
    parameter int MULT_STAGES = alpha_pkg::DEFAULT_MULT_STAGES
) (
    input  logic                   iClock,
    input  logic                   rst_n,

    // Term input
    input  logic                   in_valid,
    output logic                   in_ready,
    input  alpha_pkg::coef_t       in_acf1,
    input  alpha_pkg::coef_t       in_acf2,
    input  alpha_pkg::coef_t       in_model1,
    input  alpha_pkg::coef_t       in_model2,
    input  logic                   in_last,

    // Frame result
    output logic                   alpha_valid,
    input  logic                   alpha_ready,
    output alpha_pkg::acc_t        alpha,
    output alpha_pkg::term_count_t alpha_terms
);

    product_if prod_a ();
    product_if prod_b ();

    // acf2 * model1
    product_lane #(
        .MULT_STAGES (MULT_STAGES)
    ) lane_a (
        .iClock   (iClock),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),   // Lanes move together, one ready suffices
        .in_a     (in_acf2),
        .in_b     (in_model1),
        .in_last  (in_last),
        .out      (prod_a.source)
    );

    // acf1 * model2
    product_lane #(
        .MULT_STAGES (MULT_STAGES)
    ) lane_b (
        .iClock   (iClock),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (),
        .in_a     (in_acf1),
        .in_b     (in_model2),
        .in_last  (in_last),
        .out      (prod_b.source)
    );

    alpha_accumulator u_accumulator (
        .iClock      (iClock),
        .rst_n       (rst_n),
        .lane_a      (prod_a.sink),
        .lane_b      (prod_b.sink),
        .alpha_valid (alpha_valid),
        .alpha_ready (alpha_ready),
        .alpha       (alpha),
        .alpha_terms (alpha_terms)
    );

endmodule

//--- tb/alpha_calculator_tb.sv
// Runs with MULT_STAGES 3; random frames hold at most 16 terms and the full-scale frame 255
`timescale 1ns/1ns

module alpha_calculator_tb;

    import alpha_pkg::*;

    localparam int MULT_STAGES   = 3;
    localparam int NUM_FRAMES    = 8;
    localparam int MAX_ROWS      = 512;
    localparam int HS_TIMEOUT    = 200;    // Cycles allowed for one input handshake
    localparam int DRAIN_TIMEOUT = 3000;   // Cycles allowed for pending results

    typedef struct packed {
        int   count;
        int   first;           // First row in the coefficient table
        logic random_ready;    // Random output back-pressure
        logic check_latency;
    } frame_t;

    logic        iClock;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    coef_t       in_acf1;
    coef_t       in_acf2;
    coef_t       in_model1;
    coef_t       in_model2;
    logic        in_last;
    logic        alpha_valid;
    logic        alpha_ready;
    acc_t        alpha;
    term_count_t alpha_terms;

    frame_t frames [NUM_FRAMES];
    coef_t  acf1_tab [MAX_ROWS];
    coef_t  acf2_tab [MAX_ROWS];
    coef_t  model1_tab [MAX_ROWS];
    coef_t  model2_tab [MAX_ROWS];

    integer seed;
    logic   random_ready;
    logic   timed_out;
    int     cycle;
    int     stall_cycles;
    int     mismatch_count;
    int     failure_count;

    acc_t        exp_alpha_q [$];
    term_count_t exp_terms_q [$];
    logic        latency_flag_q [$];
    int          last_hs_q [$];       // Cycle of each frame-end handshake

    logic        prev_valid;
    logic        prev_ready;
    acc_t        prev_alpha;
    term_count_t prev_terms;

    alpha_calculator #(
        .MULT_STAGES (MULT_STAGES)
    ) DUT (
        .iClock      (iClock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_acf1     (in_acf1),
        .in_acf2     (in_acf2),
        .in_model1   (in_model1),
        .in_model2   (in_model2),
        .in_last     (in_last),
        .alpha_valid (alpha_valid),
        .alpha_ready (alpha_ready),
        .alpha       (alpha),
        .alpha_terms (alpha_terms)
    );

    always #2 iClock = ~iClock;

    always @(posedge iClock) begin
        #1;
        if (!random_ready)
            alpha_ready = 1'b1;
        else
            alpha_ready = (($random(seed) & 3) == 0);   // High one cycle in four
    end

    task automatic set_row(int r, coef_t a1, coef_t a2, coef_t m1, coef_t m2);
        acf1_tab[r]   = a1;
        acf2_tab[r]   = a2;
        model1_tab[r] = m1;
        model2_tab[r] = m2;
    endtask

    task automatic set_frame(int f, int count, int first, logic rnd, logic lat);
        frames[f].count         = count;
        frames[f].first         = first;
        frames[f].random_ready  = rnd;
        frames[f].check_latency = lat;
    endtask

    task automatic build_table();
        int row;
        int n;
        set_frame(0, 1, 0, 1'b0, 1'b1);
        set_row(0, 16'h2000, 16'h4000, 16'h6000, 16'hc000);
        // Twelve terms with mixed signs
        set_frame(1, 12, 1, 1'b0, 1'b1);
        set_row(1, 16'h7fff, 16'h8001, 16'h1234, 16'hedcb);
        set_row(2, 16'hc000, 16'h3fff, 16'h8000, 16'h0001);
        set_row(3, 16'h0abc, 16'hf543, 16'h7fff, 16'h7fff);
        set_row(4, 16'hffff, 16'h0001, 16'hffff, 16'h8000);
        set_row(5, 16'h5a5a, 16'ha5a5, 16'h3c3c, 16'hc3c3);
        set_row(6, 16'h0000, 16'h7fff, 16'h0000, 16'h8000);
        set_row(7, 16'h8000, 16'h8000, 16'h7fff, 16'h0100);
        set_row(8, 16'h1111, 16'he000, 16'h2222, 16'hf0f0);
        set_row(9, 16'hfedc, 16'h0123, 16'hba98, 16'h4567);
        set_row(10, 16'h4000, 16'hc001, 16'h9999, 16'h6666);
        set_row(11, 16'h0fff, 16'hf001, 16'h8421, 16'h1248);
        set_row(12, 16'hd00d, 16'h2bad, 16'hbeef, 16'h0c0c);
        // Full scale, 255 terms at the most negative value
        set_frame(2, 255, 13, 1'b0, 1'b1);
        for (int r = 13; r < 268; r++) begin
            set_row(r, 16'h8000, 16'h8000, 16'h8000, 16'h8000);
        end
        row = 268;
        for (int f = 3; f < NUM_FRAMES; f++) begin
            n = 1 + ($random(seed) & 15);
            set_frame(f, n, row, 1'b1, 1'b0);
            for (int t = 0; t < n; t++) begin
                set_row(row, coef_t'($random(seed)), coef_t'($random(seed)),
                        coef_t'($random(seed)), coef_t'($random(seed)));
                row++;
            end
        end
    endtask

    // Reference sum of acf2*model1 + acf1*model2 over a frame
    function automatic acc_t model_alpha(int first, int count);
        longint sum;
        sum = 0;
        for (int r = first; r < first + count; r++) begin
            sum += longint'(acf2_tab[r]) * longint'(model1_tab[r])
                 + longint'(acf1_tab[r]) * longint'(model2_tab[r]);
        end
        return acc_t'(sum);
    endfunction

    task automatic end_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    endtask

    task automatic report_timeout(string what);
        $display("timeout while waiting for %s", what);
        failure_count++;
        timed_out = 1'b1;
    endtask

    task automatic check_latency();
        int   hs_cycle;
        logic flag;
        assert (last_hs_q.size() > 0 && latency_flag_q.size() > 0) else begin
            $display("result appeared without a frame end accepted at the input");
            failure_count++;
        end
        if (last_hs_q.size() > 0 && latency_flag_q.size() > 0) begin
            hs_cycle = last_hs_q.pop_front();
            flag     = latency_flag_q.pop_front();
            if (flag) begin
                assert (cycle - hs_cycle == MULT_STAGES + 1) else begin
                    $display("mismatch alpha_valid latency: got %h expected %h",
                             cycle - hs_cycle, MULT_STAGES + 1);
                    mismatch_count++;
                end
            end
        end
    endtask

    task automatic check_result();
        acc_t        exp_alpha;
        term_count_t exp_terms;
        assert (exp_alpha_q.size() > 0) else begin
            $display("result taken while no frame was outstanding");
            failure_count++;
        end
        if (exp_alpha_q.size() > 0) begin
            exp_alpha = exp_alpha_q.pop_front();
            exp_terms = exp_terms_q.pop_front();
            assert (alpha == exp_alpha) else begin
                $display("mismatch alpha: got %h expected %h", alpha, exp_alpha);
                mismatch_count++;
            end
            assert (alpha_terms == exp_terms) else begin
                $display("mismatch alpha_terms: got %h expected %h", alpha_terms, exp_terms);
                mismatch_count++;
            end
        end
    endtask

    // Output monitor, samples on the rising edge
    always @(posedge iClock) begin
        if (rst_n) begin
            if (in_valid && !in_ready)
                stall_cycles++;
            if (in_valid && in_ready && in_last)
                last_hs_q.push_back(cycle);
            if (alpha_valid && !prev_valid)
                check_latency();
            if (prev_valid && !prev_ready) begin   // Result was waiting
                assert (alpha_valid) else begin
                    $display("mismatch alpha_valid while held: got %h expected %h",
                             alpha_valid, 1'b1);
                    mismatch_count++;
                end
                assert (alpha == prev_alpha) else begin
                    $display("mismatch alpha while held: got %h expected %h", alpha, prev_alpha);
                    mismatch_count++;
                end
                assert (alpha_terms == prev_terms) else begin
                    $display("mismatch alpha_terms while held: got %h expected %h",
                             alpha_terms, prev_terms);
                    mismatch_count++;
                end
            end
            if (alpha_valid && alpha_ready)
                check_result();
        end
        prev_valid = alpha_valid;
        prev_ready = alpha_ready;
        prev_alpha = alpha;
        prev_terms = alpha_terms;
        cycle      = cycle + 1;
    end

    task automatic send_frame(int f);
        int r;
        int waited;
        exp_alpha_q.push_back(model_alpha(frames[f].first, frames[f].count));
        exp_terms_q.push_back(term_count_t'(frames[f].count));
        latency_flag_q.push_back(frames[f].check_latency);
        random_ready <= frames[f].random_ready;
        for (int t = 0; t < frames[f].count; t++) begin
            r         = frames[f].first + t;
            in_valid  = 1'b1;
            in_acf1   = acf1_tab[r];
            in_acf2   = acf2_tab[r];
            in_model1 = model1_tab[r];
            in_model2 = model2_tab[r];
            in_last   = (t == frames[f].count - 1);
            waited    = 0;
            @(posedge iClock);
            while (!in_ready && waited < HS_TIMEOUT) begin
                @(posedge iClock);
                waited++;
            end
            if (!in_ready) begin
                report_timeout("the input handshake");
                return;
            end
            #1;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_alpha_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge iClock);
            #1;
            waited++;
        end
        if (exp_alpha_q.size() > 0)
            report_timeout("the pending results");
    endtask

    initial begin
        iClock         = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_acf1        = '0;
        in_acf2        = '0;
        in_model1      = '0;
        in_model2      = '0;
        in_last        = 1'b0;
        alpha_ready    = 1'b0;
        seed           = 32'hc4f6752a;
        random_ready   = 1'b0;
        timed_out      = 1'b0;
        cycle          = 0;
        stall_cycles   = 0;
        mismatch_count = 0;
        failure_count  = 0;
        prev_valid     = 1'b0;
        prev_ready     = 1'b0;
        prev_alpha     = '0;
        prev_terms     = '0;
        build_table();
        repeat (3) @(posedge iClock);
        #1;
        rst_n = 1'b1;
        assert (alpha_valid === 1'b0) else begin
            $display("mismatch alpha_valid after reset: got %h expected %h", alpha_valid, 1'b0);
            mismatch_count++;
        end
        assert (in_ready === 1'b1) else begin
            $display("mismatch in_ready after reset: got %h expected %h", in_ready, 1'b1);
            mismatch_count++;
        end
        for (int f = 0; f < NUM_FRAMES && !timed_out; f++) begin
            if (frames[f].check_latency) begin
                in_valid = 1'b0;   // Start from an idle pipeline
                wait_drain();
            end
            if (!timed_out)
                send_frame(f);
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        if (!timed_out)
            wait_drain();
        if (!timed_out) begin
            assert (stall_cycles > 0) else begin
                $display("in_ready never fell while the output was stalled");
                failure_count++;
            end
        end
        end_run();
    end

endmodule

//--- alpha_calculator.f
hdl/alpha_pkg.sv
hdl/product_if.sv
hdl/product_lane.sv
hdl/alpha_accumulator.sv
hdl/alpha_calculator.sv
tb/alpha_calculator_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = alpha_calculator_tb
FILELIST  = alpha_calculator.f
BUILD_DIR = obj_dir

PASS_TEXT = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless the run passes"
	@echo "  clean  remove the build folder"
	@echo "  help   list these targets"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
